// File: hdl/led_pkg.sv
package led_pkg;

  // panel geometry
  localparam int led_cols      = 32;  // columns per half, power of two
  localparam int led_scan_rows = 8;   // row pairs
  localparam int led_planes    = 8;   // bcm bit planes

  localparam int led_col_w   = $clog2(led_cols);
  localparam int led_row_w   = $clog2(led_scan_rows);
  localparam int led_plane_w = $clog2(led_planes);
  localparam int led_addr_w  = 1 + led_row_w + led_col_w;  // {half, row, col}

  localparam int led_pix_bytes = 3;
  localparam int led_pix_w     = 8 * led_pix_bytes;
  localparam int led_delay_w   = 8;

  localparam logic [led_plane_w-1:0] led_top_plane = led_plane_w'(led_planes - 1);
  localparam logic [led_delay_w-1:0] led_step_hold = 8'd255;  // 256 dark cycles

  // delay load per plane, index is the plane number
  localparam logic [led_planes-1:0][led_delay_w-1:0] plane_weight = {
    8'd255, 8'd128, 8'd64, 8'd32, 8'd16, 8'd8, 8'd4, 8'd2
  };

  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [led_addr_w-1:0]    adr;     // word address
    logic [led_pix_bytes-1:0] sel;
    logic [led_pix_w-1:0]     dat;
  } wb_req_t;

  typedef struct packed {
    logic                 ack;
    logic                 stall;
    logic [led_pix_w-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } pixel_t;

  typedef union packed {
    pixel_t                        pix;
    logic [led_pix_bytes-1:0][7:0] bytes;  // bytes[2] is red
  } pixel_u;

  typedef struct packed {
    logic [led_row_w-1:0] demux;
    logic [2:0]           upper;   // r,g,b of the top half
    logic [2:0]           lower;   // r,g,b of the bottom half
    logic                 stb;
    logic                 clk;
    logic                 oe_n;
  } panel_t;

  typedef enum logic [2:0] {
    st_idle, st_read1, st_read2, st_clock, st_latch, st_delay, st_step
  } scan_state_t;

endpackage

// File: hdl/wb_pixel_port.sv
module wb_pixel_port (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  led_pkg::wb_req_t                    bus_i,
  output led_pkg::wb_rsp_t                    bus_o,
  output logic                                mem_we_o,
  output logic [led_pkg::led_addr_w-1:0]      mem_adr_o,
  output logic [led_pkg::led_pix_bytes-1:0]   mem_sel_o,
  output led_pkg::pixel_u                     mem_wdat_o,
  input  led_pkg::pixel_u                     mem_rdat_i
);

  logic            accept;
  logic [1:0]      beat_q;   // accepted beats in flight
  led_pkg::pixel_u rdat_q;

  // no back-pressure, every strobed cycle is a beat
  assign accept = bus_i.cyc & bus_i.stb;

  assign mem_we_o   = accept & bus_i.we;
  assign mem_adr_o  = bus_i.adr;
  assign mem_sel_o  = bus_i.sel;
  assign mem_wdat_o = bus_i.dat;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      beat_q <= '0;
    end
    else
    begin
      beat_q <= {beat_q[0], accept};
    end
  end

  // memory data arrives one cycle after the beat, hold it for the ack
  always_ff @(posedge clk_i)
  begin
    if (beat_q[0])
    begin
      rdat_q <= mem_rdat_i;
    end
  end

  always_comb
  begin
    bus_o.ack   = beat_q[1];
    bus_o.stall = 1'b0;
    bus_o.dat   = rdat_q;
  end

  a_ack_has_request : assert property (
    @(posedge clk_i) disable iff (rst_i)
    bus_o.ack |-> $past(accept, 2)
  );

endmodule

// File: hdl/frame_mem.sv
module frame_mem (
  input  logic                                clk_i,
  input  logic                                host_we_i,
  input  logic [led_pkg::led_addr_w-1:0]      host_adr_i,
  input  logic [led_pkg::led_pix_bytes-1:0]   host_sel_i,
  input  led_pkg::pixel_u                     host_wdat_i,
  output led_pkg::pixel_u                     host_rdat_o,
  input  logic [led_pkg::led_addr_w-1:0]      scan_adr_i,
  output led_pkg::pixel_u                     scan_rdat_o
);

  led_pkg::pixel_u mem [0:(1 << led_pkg::led_addr_w)-1];

  // host side, byte lanes written independently
  always_ff @(posedge clk_i)
  begin
    if (host_we_i)
    begin
      for (int b = 0; b < led_pkg::led_pix_bytes; b++)
      begin
        if (host_sel_i[b])
        begin
          mem[host_adr_i].bytes[b] <= host_wdat_i.bytes[b];
        end
      end
    end
    host_rdat_o <= mem[host_adr_i];  // old data on a write
  end

  // scan side is read only
  always_ff @(posedge clk_i)
  begin
    scan_rdat_o <= mem[scan_adr_i];
  end

endmodule

// File: hdl/pwm_scanner.sv
module pwm_scanner (
  input  logic                           clk_i,
  input  logic                           rst_i,
  output logic [led_pkg::led_addr_w-1:0] scan_adr_o,
  input  led_pkg::pixel_u                scan_rdat_i,
  output led_pkg::panel_t                panel_o
);

  led_pkg::scan_state_t state_q, state_d;

  logic                              half_q, half_d;
  logic [led_pkg::led_col_w-1:0]     col_q, col_d;
  logic [led_pkg::led_row_w-1:0]     row_q, row_d;
  logic [led_pkg::led_plane_w-1:0]   plane_q, plane_d;
  logic [led_pkg::led_delay_w-1:0]   delay_q, delay_d;
  logic [2:0]                        upper_q, upper_d;
  logic [2:0]                        lower_q, lower_d;

  led_pkg::pixel_t pix;
  logic [2:0]      plane_rgb;

  assign pix       = scan_rdat_i.pix;
  assign plane_rgb = {pix.red[plane_q], pix.green[plane_q], pix.blue[plane_q]};

  assign scan_adr_o = {half_q, row_q, col_q};

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= led_pkg::st_idle;
      half_q  <= 1'b0;
      col_q   <= '0;
      row_q   <= '0;
      plane_q <= led_pkg::led_top_plane;
      delay_q <= '0;
      upper_q <= '0;
      lower_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      half_q  <= half_d;
      col_q   <= col_d;
      row_q   <= row_d;
      plane_q <= plane_d;
      delay_q <= delay_d;
      upper_q <= upper_d;
      lower_q <= lower_d;
    end
  end

  always_comb
  begin
    state_d = state_q;
    half_d  = half_q;
    col_d   = col_q;
    row_d   = row_q;
    plane_d = plane_q;
    delay_d = delay_q;
    upper_d = upper_q;
    lower_d = lower_q;

    case (state_q)
      led_pkg::st_idle:
      begin
        state_d = led_pkg::st_read1;
        half_d  = ~half_q;  // top half word is on the bus already
      end
      led_pkg::st_read1:
      begin
        state_d = led_pkg::st_read2;
        half_d  = ~half_q;
        upper_d = plane_rgb;
      end
      led_pkg::st_read2:
      begin
        state_d = led_pkg::st_clock;
        lower_d = plane_rgb;
        col_d   = col_q + 1'b1;  // wraps to 0 after the last column
      end
      led_pkg::st_clock:
      begin
        if (col_q == '0)
        begin
          state_d = led_pkg::st_latch;
        end
        else
        begin
          state_d = led_pkg::st_idle;
        end
      end
      led_pkg::st_latch:
      begin
        state_d = led_pkg::st_delay;
        plane_d = plane_q - 1'b1;  // 0 wraps to 7
        delay_d = led_pkg::plane_weight[plane_q];
      end
      led_pkg::st_delay:
      begin
        if (delay_q == '0)
        begin
          state_d = led_pkg::st_step;
          delay_d = led_pkg::led_step_hold;
        end
        else
        begin
          delay_d = delay_q - 1'b1;
        end
      end
      led_pkg::st_step:
      begin
        if (delay_q == '0)
        begin
          state_d = led_pkg::st_idle;
          // plane already wrapped, so plane 0 was the one just shown
          if (plane_q == led_pkg::led_top_plane)
          begin
            row_d = row_q + 1'b1;
          end
        end
        else
        begin
          delay_d = delay_q - 1'b1;
        end
      end
      default:
      begin
        state_d = led_pkg::st_idle;
      end
    endcase
  end

  always_comb
  begin
    panel_o.demux = row_q;
    panel_o.upper = upper_q;
    panel_o.lower = lower_q;
    panel_o.stb   = (state_q == led_pkg::st_latch);
    panel_o.clk   = (state_q == led_pkg::st_clock);
    panel_o.oe_n  = (state_q != led_pkg::st_delay);  // lit only while counting the weight
  end

  a_clk_stb_apart : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(panel_o.clk && panel_o.stb)
  );

  // latch comes straight after the last column clock
  a_latch_after_clock : assert property (
    @(posedge clk_i) disable iff (rst_i)
    panel_o.stb |-> $past(panel_o.clk)
  );

  a_dark_at_latch : assert property (
    @(posedge clk_i) disable iff (rst_i)
    panel_o.stb |-> panel_o.oe_n ##1 !panel_o.oe_n
  );

endmodule

// File: hdl/led_matrix.sv
module led_matrix (
  input  logic             clk_i,
  input  logic             rst_i,
  input  led_pkg::wb_req_t bus_i,
  output led_pkg::wb_rsp_t bus_o,
  output led_pkg::panel_t  panel_o
);

  logic                              mem_we;
  logic [led_pkg::led_addr_w-1:0]    mem_adr;
  logic [led_pkg::led_pix_bytes-1:0] mem_sel;
  led_pkg::pixel_u                   mem_wdat;
  led_pkg::pixel_u                   mem_rdat;
  logic [led_pkg::led_addr_w-1:0]    scan_adr;
  led_pkg::pixel_u                   scan_rdat;

  wb_pixel_port u_port (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .bus_i      (bus_i),
    .bus_o      (bus_o),
    .mem_we_o   (mem_we),
    .mem_adr_o  (mem_adr),
    .mem_sel_o  (mem_sel),
    .mem_wdat_o (mem_wdat),
    .mem_rdat_i (mem_rdat)
  );

  frame_mem u_mem (
    .clk_i       (clk_i),
    .host_we_i   (mem_we),
    .host_adr_i  (mem_adr),
    .host_sel_i  (mem_sel),
    .host_wdat_i (mem_wdat),
    .host_rdat_o (mem_rdat),
    .scan_adr_i  (scan_adr),
    .scan_rdat_o (scan_rdat)
  );

  pwm_scanner u_scan (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .scan_adr_o  (scan_adr),
    .scan_rdat_i (scan_rdat),
    .panel_o     (panel_o)
  );

endmodule

// File: bench/matrix_checker.sv
module matrix_checker (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic [2:0]       test_id_i,
  input  logic             arm_i,      // data checks start at the next latch
  input  led_pkg::wb_req_t bus_req_i,
  input  led_pkg::wb_rsp_t bus_rsp_i,
  input  led_pkg::panel_t  panel_i
);

  int errs [1:6];
  int chks [1:6];
  int total_errors;
  int planes_checked;
  int plane_cur;   // plane whose columns are being shifted
  int lit_plane;
  int col_cnt;
  int lo_cnt;
  int exp_row;
  logic        scan_on;
  logic [1:0]  ack_pipe;
  logic [1:0]  rd_pipe;
  logic [23:0] dat_pipe [0:1];

  function automatic string test_name(input int id);
    case (id)
      1: return "reset state";
      2: return "bus write read";
      3: return "byte enables";
      4: return "shifted data";
      5: return "plane weighting";
      6: return "writes during scan";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input int id, input logic [31:0] exp, input logic [31:0] act,
                             input string what);
    chks[id]++;
    if (act !== exp)
    begin
      errs[id]++;
      total_errors++;
      $display("[FAIL] %s: expected %0h, actual %0h (%s)", test_name(id), exp, act, what);
    end
  endtask

  task automatic word_error(input int id, input string msg);
    chks[id]++;
    errs[id]++;
    total_errors++;
    $display("ERROR in %s: %s", test_name(id), msg);
  endtask

  task automatic check_bus();
    int id;
    id = test_id_i;
    if (bus_rsp_i.ack !== ack_pipe[1])
    begin
      if (ack_pipe[1])
        word_error(id, "no ack two cycles after an accepted request");
      else
        word_error(id, "ack seen without a request two cycles earlier");
    end
    else if (ack_pipe[1] && rd_pipe[1])
      check_value(id, dat_pipe[1], bus_rsp_i.dat, "read data");
    if (bus_req_i.cyc & bus_req_i.stb)
      check_value(id, 0, bus_rsp_i.stall, "stall");
    ack_pipe[1] = ack_pipe[0];
    rd_pipe[1]  = rd_pipe[0];
    dat_pipe[1] = dat_pipe[0];
    ack_pipe[0] = bus_req_i.cyc & bus_req_i.stb;
    rd_pipe[0]  = ~bus_req_i.we;
    dat_pipe[0] = tb_top.shadow[bus_req_i.adr];  // image as seen at acceptance
  endtask

  task automatic check_panel();
    int         id;
    logic [5:0] exp_rgb;
    id = (test_id_i == 3'd6) ? 6 : 4;
    if (panel_i.clk)
    begin
      if (scan_on)
      begin
        exp_rgb = tb_top.expect_rgb(panel_i.demux, col_cnt, plane_cur);
        check_value(id, exp_rgb, {panel_i.upper, panel_i.lower},
                    $sformatf("row %0d col %0d plane %0d", panel_i.demux, col_cnt, plane_cur));
      end
      col_cnt++;
    end
    if (!panel_i.oe_n)
      lo_cnt++;
    else if (lo_cnt != 0)
    begin
      check_value(5, int'(led_pkg::plane_weight[lit_plane]) + 1, lo_cnt, "oe_n low cycles");
      lo_cnt = 0;
    end
    if (panel_i.stb)
    begin
      check_value(5, led_pkg::led_cols, col_cnt, "column clocks before latch");
      check_value(5, exp_row, panel_i.demux, "row at latch");
      if (scan_on)
        planes_checked++;
      scan_on   = scan_on | arm_i;
      lit_plane = plane_cur;
      if (plane_cur == 0)
      begin
        plane_cur = led_pkg::led_planes - 1;
        exp_row   = (exp_row + 1) % led_pkg::led_scan_rows;
      end
      else
        plane_cur--;
      col_cnt = 0;
    end
  endtask

  always @(negedge rst_i)
  begin
    check_value(1, 0, panel_i.clk, "panel clk");
    check_value(1, 0, panel_i.stb, "panel stb");
    check_value(1, 1, panel_i.oe_n, "oe_n");
    check_value(1, 0, panel_i.demux, "demux");
    check_value(1, 0, bus_rsp_i.ack, "ack");
  end

  always @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ack_pipe  = '0;
      rd_pipe   = '0;
      plane_cur = led_pkg::led_planes - 1;
      lit_plane = plane_cur;
      col_cnt   = 0;
      lo_cnt    = 0;
      exp_row   = 0;
      scan_on   = 1'b0;
    end
    else
    begin
      check_bus();
      check_panel();
    end
  end

  task automatic finish_test(input int id);
    $display("test %0d %s: %0d checks, %0d errors", id, test_name(id), chks[id], errs[id]);
  endtask

  task automatic report_summary();
    int checks;
    checks = 0;
    for (int i = 1; i <= 6; i++)
      checks += chks[i];
    $display("summary: 6 tests, %0d checks, %0d errors", checks, total_errors);
  endtask

endmodule

// File: bench/tb_top.sv
module tb_top;

  localparam int n_words   = 1 << led_pkg::led_addr_w;
  localparam int n_partial = 64;

  logic             clk;
  logic             rst;
  logic [2:0]       test_id;
  logic             scan_arm;
  led_pkg::wb_req_t bus_req;
  led_pkg::wb_rsp_t bus_rsp;
  led_pkg::panel_t  panel;

  logic [23:0]                    shadow [0:n_words-1];
  logic [led_pkg::led_addr_w-1:0] part_adr [0:n_partial-1];

  int sent;
  int acked;
  int cycle_cnt;
  int timeout_cycles;
  int seed_val;

  led_matrix u_dut (
    .clk_i   (clk),
    .rst_i   (rst),
    .bus_i   (bus_req),
    .bus_o   (bus_rsp),
    .panel_o (panel)
  );

  matrix_checker u_check (
    .clk_i     (clk),
    .rst_i     (rst),
    .test_id_i (test_id),
    .arm_i     (scan_arm),
    .bus_req_i (bus_req),
    .bus_rsp_i (bus_rsp),
    .panel_i   (panel)
  );

  // {upper rgb, lower rgb} of one column pair on one bit plane
  function automatic logic [5:0] expect_rgb(input int row, input int col, input int plane);
    logic [23:0] top;
    logic [23:0] bot;
    top = shadow[row * led_pkg::led_cols + col];
    bot = shadow[(led_pkg::led_scan_rows + row) * led_pkg::led_cols + col];
    return {top[16+plane], top[8+plane], top[plane], bot[16+plane], bot[8+plane], bot[plane]};
  endfunction

  function automatic logic [23:0] merge_word(input logic [23:0] old_w, input logic [23:0] new_w,
                                             input logic [2:0] sel);
    logic [23:0] w;
    w = old_w;
    for (int b = 0; b < 3; b++)
      if (sel[b])
        w[8*b +: 8] = new_w[8*b +: 8];
    return w;
  endfunction

  function automatic logic [23:0] rand_pixel();
    logic [31:0] r;
    r = $urandom();
    return r[23:0];
  endfunction

  function automatic int scan_row_cycles();
    int total;
    total = 0;
    for (int p = 0; p < led_pkg::led_planes; p++)
      total += 4 * led_pkg::led_cols + int'(led_pkg::plane_weight[p]) + 260;
    return total;
  endfunction

  initial
  begin
    clk = 1'b0;
    forever
      #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (bus_rsp.ack === 1'b1)
      acked <= acked + 1;
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cycles)
    begin
      $display("timeout: run did not end within %0d cycles", timeout_cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic bus_issue(input logic we, input int adr, input logic [2:0] sel,
                           input logic [23:0] dat);
    @(negedge clk);
    bus_req.cyc = 1'b1;
    bus_req.stb = 1'b1;
    bus_req.we  = we;
    bus_req.adr = adr[led_pkg::led_addr_w-1:0];
    bus_req.sel = sel;
    bus_req.dat = dat;
    if (we)
      shadow[adr] = merge_word(shadow[adr], dat, sel);
    sent++;
  endtask

  // drop the strobe and wait for every ack of the burst
  task automatic bus_settle();
    int waited;
    @(negedge clk);
    bus_req.cyc = 1'b0;
    bus_req.stb = 1'b0;
    waited = 0;
    while (acked != sent && waited < 8)
    begin
      @(posedge clk);
      waited++;
    end
    if (acked != sent)
      u_check.word_error(test_id, "acks still missing after the burst ended");
  endtask

  task automatic sweep_words(input logic we);
    int a;
    int len;
    a = 0;
    while (a < n_words)
    begin
      len = $urandom_range(8, 1);
      for (int k = 0; k < len && a < n_words; k++)
      begin
        bus_issue(we, a, 3'b111, rand_pixel());
        a++;
      end
      bus_settle();
    end
  endtask

  task automatic wait_latch();
    @(posedge clk);
    while (!panel.stb)
      @(posedge clk);
  endtask

  // rewrite one pixel of the row that the next plane will show
  task automatic rewrite_pixel();
    int          row;
    logic [31:0] r;
    @(negedge clk);
    row = panel.demux;
    if (u_check.plane_cur == led_pkg::led_planes - 1)
      row = (row + 1) % led_pkg::led_scan_rows;
    r = $urandom();
    bus_issue(1'b1, r[8] * led_pkg::led_scan_rows * led_pkg::led_cols
              + row * led_pkg::led_cols + r[4:0], r[11:9], rand_pixel());
    bus_settle();
  endtask

  initial
  begin
    seed_val = $urandom(94);
    timeout_cycles = 6 * (2 * n_words + 2 * n_partial) + 3 * scan_row_cycles();
    rst      = 1'b1;
    test_id  = 3'd1;
    scan_arm = 1'b0;
    bus_req  = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    u_check.finish_test(1);

    test_id = 3'd2;
    sweep_words(1'b1);
    sweep_words(1'b0);
    u_check.finish_test(2);

    @(negedge clk);
    test_id = 3'd3;
    for (int i = 0; i < n_partial; i++)
    begin
      part_adr[i] = $urandom_range(n_words - 1, 0);
      bus_issue(1'b1, part_adr[i], $urandom_range(7, 0), rand_pixel());
      if (i % 8 == 7)
        bus_settle();
    end
    for (int i = 0; i < n_partial; i++)
    begin
      bus_issue(1'b0, part_adr[i], 3'b111, 24'h0);
      if (i % 8 == 7)
        bus_settle();
    end
    u_check.finish_test(3);

    @(negedge clk);
    test_id  = 3'd4;
    scan_arm = 1'b1;
    while (u_check.planes_checked < 2 * led_pkg::led_planes)
      @(negedge clk);
    u_check.finish_test(4);

    test_id = 3'd6;
    repeat (4)
    begin
      wait_latch();
      rewrite_pixel();
    end
    wait_latch();
    u_check.finish_test(5);
    u_check.finish_test(6);

    u_check.report_summary();
    if (u_check.total_errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: tb.f
hdl/led_pkg.sv
hdl/wb_pixel_port.sv
hdl/frame_mem.sv
hdl/pwm_scanner.sv
hdl/led_matrix.sv
bench/matrix_checker.sv
bench/tb_top.sv
